// ==== Bender.yml ====
package:
  name: pluck_synth

sources:
  - include_dirs:
      - design
    files:
      - design/pluck_pkg.sv
      - design/noise_lfsr.sv
      - design/trig_debounce.sv
      - design/delay_ram.sv
      - design/loop_filter.sv
      - design/string_voice.sv
      - design/pluck_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/pluck_tb.sv

// ==== bench/pluck_tb.sv ====
`timescale 1ns/1ns
`include "pluck_consts.svh"

module pluck_tb;

	localparam int S_IDLE = 0;
	localparam int S_FILL = 1;
	localparam int S_RING = 2;
	// cycle budget per test sized from the waits below
	localparam int LEN_T1 = 60;
	localparam int LEN_T2 = 100;
	localparam int LEN_T3 = 366;
	localparam int LEN_T4 = 1036;
	localparam int LEN_T5 = 450;
	localparam int LEN_T6 = 1008;
	localparam int LIMIT  = (LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6) * 11 / 10;

	logic                        a_clk;
	logic                        reset_n;
	logic                        trig;
	logic [`ADDR_W-1:0]          delay_length;
	logic [`GAIN_W-1:0]          decay;
	logic [2:0]                  filt_sel;
	logic signed [`SAMPLE_W-1:0] qout;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] rng    = 32'hede9_f303; // stimulus lfsr state

	// reference model state
	logic [23:0]                 m_lfsr;
	logic                        m_sync0;
	logic                        m_sync1;
	logic                        m_level;
	logic                        m_pluck;
	logic                        m_wr_en;
	logic [`DEB_W-1:0]           m_cnt;
	int                          m_state;
	logic [`ADDR_W-1:0]          m_ptr;
	logic signed [`SAMPLE_W-1:0] m_mem [0:(1 << `ADDR_W) - 1];
	logic signed [`SAMPLE_W-1:0] m_rd;
	logic signed [`SAMPLE_W-1:0] m_dout;

	pluck_top uut
	(
		.a_clk        (a_clk),
		.reset_n      (reset_n),
		.trig         (trig),
		.delay_length (delay_length),
		.decay        (decay),
		.filt_sel     (filt_sel),
		.qout         (qout)
	);

	always #20 a_clk = ~a_clk; // 40 ns period

	function automatic logic [23:0] noise_next(input logic [23:0] s);
		return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]}; // taps 24,23,22,17
	endfunction

	function automatic logic [31:0] rng_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
	endfunction

	// one-pole step moves the output toward the input by diff >>> sel
	function automatic logic signed [`SAMPLE_W-1:0] filter_step(
		input logic signed [`SAMPLE_W-1:0] y, input logic signed [`SAMPLE_W-1:0] x,
		input logic [2:0] sel);
		longint d;
		longint a;
		d = longint'(x) - longint'(y);
		a = longint'(y) + (d >>> sel);
		return a[`SAMPLE_W-1:0];
	endfunction

	// feedback times gain where 4096 is unity
	function automatic logic signed [`SAMPLE_W-1:0] gain_step(
		input logic signed [`SAMPLE_W-1:0] fb, input logic [`GAIN_W-1:0] g);
		longint p;
		p = longint'(fb) * longint'({1'b0, g});
		p = p >>> `GAIN_SHIFT;
		return p[`SAMPLE_W-1:0];
	endfunction

	function automatic int mag(input logic signed [`SAMPLE_W-1:0] s);
		int v;
		v = s;
		return (v < 0) ? -v : v;
	endfunction

	task automatic rand_bits(input int n, output int v);
		int i;
		v = 0;
		for (i = 0; i < n; i++)
		begin
			rng = rng_next(rng); // one step per bit taken
			v = (v << 1) | rng[0];
		end
	endtask

	task automatic model_reset();
		m_lfsr  = 24'h5a_c3e1;
		m_sync0 = 1'b0;
		m_sync1 = 1'b0;
		m_level = 1'b0;
		m_cnt   = '0;
		m_pluck = 1'b0;
		m_wr_en = 1'b0;
		m_state = S_IDLE;
		m_ptr   = '0;
		m_rd    = '0;
		m_dout  = '0; // line contents survive reset
	endtask

	task automatic model_step();
		logic signed [`SAMPLE_W-1:0] wr_data;
		logic signed [`SAMPLE_W-1:0] rd_next;
		logic                        at_end;
		logic                        pluck_next;
		wr_data = (m_state == S_FILL) ? $signed(m_lfsr) :
			(m_state == S_RING) ? gain_step(m_dout, decay) : '0;
		rd_next = (m_state != S_IDLE) ? m_mem[m_ptr] : '0; // old contents
		if (m_wr_en)
			m_mem[m_ptr] = wr_data; // write after read
		m_dout  = filter_step(m_dout, m_rd, filt_sel);
		m_rd    = rd_next;
		m_wr_en = 1'b1;
		at_end  = m_ptr >= delay_length;
		if (m_pluck)
		begin
			m_state = S_FILL; // restart from any state
			m_ptr   = '0;
		end
		else
		begin
			if (m_state == S_FILL && at_end)
				m_state = S_RING;
			m_ptr = at_end ? '0 : m_ptr + 1'b1;
		end
		pluck_next = 1'b0;
		if (m_sync1 == m_level)
			m_cnt = '0; // stable so no change pending
		else if (&m_cnt)
		begin
			m_level    = m_sync1;
			m_cnt      = '0;
			pluck_next = m_sync1; // press only
		end
		else
			m_cnt = m_cnt + 1'b1;
		m_pluck = pluck_next;
		m_sync1 = m_sync0;
		m_sync0 = trig;
		m_lfsr  = noise_next(m_lfsr);
	endtask

	// compare and then advance the model on the same edge
	always @(posedge a_clk)
	begin
		if (reset_n)
			model_reset();
		else
		begin
			checks++;
			assert (qout === m_dout)
			else
			begin
				$display("** Error: qout expected %h got %h", m_dout, qout);
				errors++;
			end
			model_step();
		end
	end

	task automatic run_cycles(input int n);
		repeat (n) @(negedge a_clk);
	endtask

	task automatic press(input int hold);
		@(negedge a_clk);
		trig = 1'b1;
		run_cycles(hold);
		trig = 1'b0; // release is debounced silently
	endtask

	task automatic bounce(input int edges);
		int w;
		repeat (edges)
		begin
			@(negedge a_clk);
			trig = 1'b1;
			rand_bits(2, w);
			run_cycles(w % 3 + 1); // high 1 to 3 cycles and never four
			trig = 1'b0;
			rand_bits(2, w);
			run_cycles(w % 3 + 1);
		end
	endtask

	task automatic wait_note(input int limit);
		int n;
		n = 0;
		while (qout == 0 && n < limit)
		begin
			@(negedge a_clk);
			n++;
		end
		assert (qout != 0)
		else
		begin
			$display("no note started within %0d cycles of the pluck", limit);
			errors++;
		end
	endtask

	initial
	begin
		int hist[$];
		int p;
		int peak;
		int prev_peak;
		int v;
		a_clk        = 1'b0;
		reset_n      = 1'b1;
		trig         = 1'b0;
		delay_length = 10'd40;
		decay        = 13'd4096;
		filt_sel     = 3'd0;
		for (int i = 0; i < (1 << `ADDR_W); i++)
			m_mem[i] = '0; // delay line powers up silent
		run_cycles(10);
		reset_n = 1'b0;

		repeat (50) // quiet after reset
		begin
			@(negedge a_clk);
			assert (qout == 0)
			else
			begin
				$display("** Error: qout expected %h got %h", 24'h0, qout);
				errors++;
			end
		end

		press(3); // too short to qualify
		run_cycles(10);
		bounce(6);
		run_cycles(20);
		assert (qout == 0)
		else
		begin
			$display("** Error: qout expected %h got %h", 24'h0, qout);
			errors++;
		end

		p = delay_length + 3; // pointer period plus two pipeline samples
		press(10);
		wait_note(4 * 41 + 20);
		run_cycles(2 * p);
		repeat (2 * p)
		begin
			@(negedge a_clk);
			hist.push_back(qout);
		end
		for (int i = 0; i < p; i++)
			assert (hist[i + p] == hist[i])
			else
			begin
				$display("** Error: qout expected %h got %h", hist[i], hist[i + p]);
				errors++;
			end

		@(negedge a_clk); // darker decaying string
		delay_length = 10'd100;
		decay        = 13'd3900;
		filt_sel     = 3'd2;
		p            = 103;
		press(10);
		run_cycles(101 + 101 + 2 * p);
		prev_peak = 0;
		for (int k = 0; k < 6; k++)
		begin
			peak = 0;
			repeat (p)
			begin
				@(negedge a_clk);
				if (mag(qout) > peak)
					peak = mag(qout);
			end
			if (k > 0)
				assert (peak <= prev_peak)
				else
				begin
					$display("** Error: qout peak expected <= %h got %h", prev_peak, peak);
					errors++;
				end
			prev_peak = peak;
		end

		filt_sel = 3'd1;
		bounce(3); // ringing note must carry on
		run_cycles(30);
		press(10); // restart during ring
		run_cycles(3 * p);

		decay = 13'd4000;
		repeat (4)
		begin
			rand_bits(6, v);
			@(negedge a_clk);
			delay_length = v[5:0] + 10'd8;
			rand_bits(3, v);
			filt_sel = v[2:0];
			press(10);
			run_cycles(delay_length + 1 + 2 * (delay_length + 3) + 20);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		while (cycles < LIMIT)
		begin
			@(posedge a_clk);
			cycles++;
		end
		$display("timeout, run did not finish within %0d cycles", LIMIT);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== design/delay_ram.sv ====
`timescale 1ns/1ns
`include "pluck_consts.svh"

interface ram_if;
	import pluck_pkg::*;

	logic    wr_en;   // write strobe
	addr_t   wr_addr; // write pointer
	sample_t wr_data; // sample going into the line
	logic    rd_en;   // read strobe, low silences rd_data
	addr_t   rd_addr; // read pointer
	sample_t rd_data; // registered read result

	modport voice
	(
		output wr_en,
		output wr_addr,
		output wr_data,
		output rd_en,
		output rd_addr,
		input  rd_data
	);

	modport mem
	(
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_en,
		input  rd_addr,
		output rd_data
	);
endinterface

module delay_ram
(
	input logic a_clk,   // sample clock
	input logic reset_n, // sync reset, active high
	ram_if.mem  bus      // port from the voice
);
	import pluck_pkg::*;

	sample_t mem [0:(1 << `ADDR_W) - 1]; // the string itself

	// power-up contents all zero so a long first string reads silence
	initial
	begin
		for (int i = 0; i < (1 << `ADDR_W); i++)
		begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (bus.wr_en)
		begin
			mem[bus.wr_addr] <= bus.wr_data; // write lands after this cycle's read
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			bus.rd_data <= '0;
		end
		else if (bus.rd_en)
		begin
			bus.rd_data <= mem[bus.rd_addr]; // old contents, read before write
		end
		else
		begin
			bus.rd_data <= '0; // quiet output when not reading
		end
	end

	// voice pointers must be resolved whenever they are used
	a_addr_known : assert property (@(posedge a_clk) disable iff (reset_n)
		(bus.wr_en -> !$isunknown(bus.wr_addr)) &&
		(bus.rd_en -> !$isunknown(bus.rd_addr)));

endmodule

// ==== design/loop_filter.sv ====
`timescale 1ns/1ns
`include "pluck_consts.svh"

module loop_filter
(
	input  logic                 a_clk,    // sample clock
	input  logic                 reset_n,  // sync reset, active high
	input  pluck_pkg::filt_sel_t filt_sel, // shift depth, 0 is bypass
	input  pluck_pkg::sample_t   din,      // sample read from the line
	output pluck_pkg::sample_t   dout      // smoothed sample
);

	logic signed [`SAMPLE_W:0] diff; // extra bit keeps din - dout from wrapping
	logic signed [`SAMPLE_W:0] step; // fraction of the gap taken this cycle
	logic signed [`SAMPLE_W:0] acc;  // next output before truncation

	assign diff = din - dout;
	assign step = diff >>> filt_sel; // arithmetic, keeps the sign of the gap
	// lands between dout and din, so the low bits always fit
	assign acc  = dout + step;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			dout <= '0;
		end
		else
		begin
			dout <= acc[`SAMPLE_W-1:0]; // deeper shift, darker and faster damping
		end
	end

endmodule

// ==== design/noise_lfsr.sv ====
`timescale 1ns/1ns
`include "pluck_consts.svh"

module noise_lfsr
(
	input  logic              a_clk,   // sample clock
	input  logic              reset_n, // sync reset, active high
	output pluck_pkg::sample_t noise   // white noise excitation
);

	logic [23:0] lfsr;     // shift register state
	logic        feedback; // xor of the taps

	// taps 24,23,22,17 give a maximal length sequence
	assign feedback = lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16];

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			lfsr <= `LFSR_SEED; // known start so the noise is repeatable
		end
		else
		begin
			lfsr <= {lfsr[22:0], feedback}; // one step per sample
		end
	end

	assign noise = $signed(lfsr); // full register as a signed sample

	// an all-zero state would lock the lfsr and kill the excitation
	a_lfsr_alive : assert property (@(posedge a_clk) disable iff (reset_n)
		lfsr != '0);

endmodule

// ==== design/pluck_consts.svh ====
`ifndef PLUCK_CONSTS_SVH
`define PLUCK_CONSTS_SVH

// audio sample width, signed
`define SAMPLE_W 24

// delay line address width, strings up to 1024 samples
`define ADDR_W 10

// decay gain width, 4096 is unity
`define GAIN_W 13

// fixed point shift applied to the gain product
`define GAIN_SHIFT 12

// debounce counter width, new level must hold four cycles
`define DEB_W 2

// noise lfsr reset value, must be nonzero
`define LFSR_SEED 24'h5a_c3e1

`endif

// ==== design/pluck_pkg.sv ====
`include "pluck_consts.svh"

package pluck_pkg;

	// signed audio sample
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// delay line address, also the string length
	typedef logic [`ADDR_W-1:0] addr_t;

	// unsigned decay gain, 4096 means unity
	typedef logic [`GAIN_W-1:0] gain_t;

	// filter depth, shift amount of the one-pole lowpass
	typedef logic [2:0] filt_sel_t;

	// voice FSM states
	typedef enum logic [1:0]
	{
		idle = 2'd0, // quiet, line being cleared
		fill = 2'd1, // loading noise excitation
		ring = 2'd2  // recirculating through filter and gain
	} voice_state_t;

endpackage

// ==== design/pluck_top.sv ====
`timescale 1ns/1ns

module pluck_top
(
	input  logic                 a_clk,        // sample clock
	input  logic                 reset_n,      // sync reset, active high
	input  logic                 trig,         // raw pluck trigger
	input  pluck_pkg::addr_t     delay_length, // tuning, period is this plus one
	input  pluck_pkg::gain_t     decay,        // sustain, 4096 is unity
	input  pluck_pkg::filt_sel_t filt_sel,     // tone darkness
	output pluck_pkg::sample_t   qout          // audio sample out
);
	import pluck_pkg::*;

	logic    pluck;   // clean one-cycle note start
	sample_t noise;   // excitation from the lfsr
	sample_t filt_q;  // filter output, loop feedback and audio

	ram_if bus (); // voice to delay line

	trig_debounce u_debounce
	(
		.a_clk   (a_clk),
		.reset_n (reset_n),
		.trig    (trig),
		.pluck   (pluck)
	);

	noise_lfsr u_noise
	(
		.a_clk   (a_clk),
		.reset_n (reset_n),
		.noise   (noise)
	);

	string_voice u_voice
	(
		.a_clk        (a_clk),
		.reset_n      (reset_n),
		.pluck        (pluck),
		.noise        (noise),
		.fb           (filt_q),
		.delay_length (delay_length),
		.decay        (decay),
		.bus          (bus.voice)
	);

	delay_ram u_ram
	(
		.a_clk   (a_clk),
		.reset_n (reset_n),
		.bus     (bus.mem)
	);

	loop_filter u_filter
	(
		.a_clk    (a_clk),
		.reset_n  (reset_n),
		.filt_sel (filt_sel),
		.din      (bus.rd_data), // straight from the ram read register
		.dout     (filt_q)
	);

	assign qout = filt_q; // the filtered loop is the audio

endmodule

// ==== design/string_voice.sv ====
`timescale 1ns/1ns
`include "pluck_consts.svh"

module string_voice
(
	input  logic               a_clk,        // sample clock
	input  logic               reset_n,      // sync reset, active high
	input  logic               pluck,        // debounced note start
	input  pluck_pkg::sample_t noise,        // excitation source
	input  pluck_pkg::sample_t fb,           // filter output fed back
	input  pluck_pkg::addr_t   delay_length, // string length minus one
	input  pluck_pkg::gain_t   decay,        // loop gain, 4096 is unity
	ram_if.voice               bus           // delay line port
);
	import pluck_pkg::*;

	voice_state_t                      state;  // FSM state
	addr_t                             ptr;    // shared read/write pointer
	logic                              at_end; // pointer at last sample of the string
	logic signed [`SAMPLE_W+`GAIN_W:0] prod;   // fb times decay, full width
	sample_t                           gained; // product scaled back to a sample

	// decay zero-extended so it multiplies as a positive number
	assign prod   = fb * $signed({1'b0, decay});
	assign gained = prod[`GAIN_SHIFT +: `SAMPLE_W]; // shift right, keep a sample's worth
	assign at_end = ptr >= delay_length; // also catches a length that just shrank

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state <= idle;
			ptr   <= '0;
		end
		else if (pluck)
		begin
			state <= fill; // a pluck restarts from any state
			ptr   <= '0;
		end
		else
		begin
			ptr <= at_end ? '0 : ptr + 1'b1; // wraps every delay_length+1
			case (state)
				idle:
				begin
					state <= idle; // keep sweeping zeros into the line
				end
				fill:
				begin
					if (at_end)
					begin
						state <= ring; // whole string loaded with noise
					end
				end
				ring:
				begin
					state <= ring; // rings until the next pluck
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	// line is written every sample once out of reset
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			bus.wr_en <= 1'b0;
		end
		else
		begin
			bus.wr_en <= 1'b1;
		end
	end

	always_comb
	begin
		case (state)
			fill:    bus.wr_data = noise;  // excitation burst
			ring:    bus.wr_data = gained; // decayed feedback
			default: bus.wr_data = '0;     // idle clears the old note
		endcase
	end

	assign bus.wr_addr = ptr;
	assign bus.rd_addr = ptr; // same slot, old contents come back
	assign bus.rd_en   = (state == fill) || (state == ring);

	// only a fresh, shorter length may leave the pointer past the end
	a_ptr_in_range : assert property (@(posedge a_clk) disable iff (reset_n)
		!$changed(delay_length) |-> ptr <= delay_length);

endmodule

// ==== design/trig_debounce.sv ====
`timescale 1ns/1ns
`include "pluck_consts.svh"

module trig_debounce
(
	input  logic a_clk,   // sample clock
	input  logic reset_n, // sync reset, active high
	input  logic trig,    // raw trigger, asynchronous
	output logic pluck    // one cycle pulse per clean press
);

	logic              sync_0;  // first synchronizer flop
	logic              sync_1;  // second synchronizer flop
	logic              level;   // debounced trigger level
	logic [`DEB_W-1:0] cnt;     // cycles the new level has held
	logic              differ;  // input disagrees with the debounced level
	logic              cnt_max; // counter saturated

	assign differ  = sync_1 != level;
	assign cnt_max = &cnt;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			sync_0 <= 1'b0;
			sync_1 <= 1'b0;
			level  <= 1'b0;
			cnt    <= '0;
			pluck  <= 1'b0;
		end
		else
		begin
			sync_0 <= trig;   // metastability guard
			sync_1 <= sync_0;
			pluck  <= 1'b0;   // default, pulse lasts a single cycle
			if (!differ)
			begin
				cnt <= '0; // glitch ended, start over
			end
			else if (cnt_max)
			begin
				level <= sync_1; // new level accepted
				cnt   <= '0;
				pluck <= sync_1; // only a press makes a pulse, release is silent
			end
			else
			begin
				cnt <= cnt + 1'b1; // still counting stable cycles
			end
		end
	end

	// the level must flip back and requalify before another pulse
	a_pluck_single : assert property (@(posedge a_clk) disable iff (reset_n)
		pluck |=> !pluck);

endmodule

// ==== pluck_synth.f ====
+incdir+design
design/pluck_pkg.sv
design/noise_lfsr.sv
design/trig_debounce.sv
design/delay_ram.sv
design/loop_filter.sv
design/string_voice.sv
design/pluck_top.sv
bench/pluck_tb.sv
